// ==== design/dacfifo_pkg.sv ====
// shared widths, thresholds and types of the DAC playback buffer
// the buffer holds 64 beats of 64 bits, read back as 256 samples of 16 bits
// thresholds are counted in beats on the write side and samples on the read side
// widths are fixed here and every module derives from them

`default_nettype none

package dacfifo_pkg;

  // ********************
  // widths
  // ********************

  localparam int AXI_DATA_W = 64;
  localparam int DAC_DATA_W = 16;
  localparam int MEM_RATIO  = AXI_DATA_W / DAC_DATA_W;
  localparam int SEL_W      = $clog2(MEM_RATIO);
  localparam int DAC_ADDR_W = 8;
  localparam int AXI_ADDR_W = DAC_ADDR_W - SEL_W;

  // ********************
  // fill thresholds
  // ********************

  localparam int BURST_LEN    = 4;
  // ready drops one burst short of full, returns at three bursts
  localparam int AXI_THR_HI   = (2 ** AXI_ADDR_W) - 1 - BURST_LEN;
  localparam int AXI_THR_LO   = 3 * BURST_LEN;
  // samples needed before the first request is served
  localparam int DAC_THR_INIT = 3 * BURST_LEN * MEM_RATIO;

  // ********************
  // types
  // ********************

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [DAC_ADDR_W-1:0] dac_addr_t;
  typedef logic [DAC_DATA_W-1:0] sample_t;

  // valid samples in the final beat, 0 means the whole beat
  typedef logic [SEL_W-1:0] last_beats_t;

  typedef struct packed {
    logic                  valid;
    logic                  last;
    logic [AXI_DATA_W-1:0] data;
  } beat_t;

endpackage

`default_nettype wire

// ==== design/gray_sync.sv ====
// pointer crossing between two clock domains
// the source pointer must move by at most one step per source clock,
// or settle before it is used (quasi-static values)
// clr is synchronous to dst_clk and clears the destination side only
// latency is one source flop plus two destination flops

`default_nettype none

module gray_sync #(
  parameter type ptr_t = dacfifo_pkg::dac_addr_t
) (
  input  logic src_clk,
  input  logic dst_clk,
  input  logic clr,
  input  ptr_t src_ptr,
  output ptr_t dst_ptr
);

  ptr_t src_gray;
  ptr_t sync_m;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the xor of all gray bits above and at it
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
    for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // source side encode
  always_ff @(posedge src_clk) begin
    src_gray <= bin2gray(src_ptr);
  end

  // two flops in the destination domain, decode folded into the second
  always_ff @(posedge dst_clk) begin
    if (clr) begin
      sync_m  <= '0;
      dst_ptr <= '0;
    end else begin
      sync_m  <= src_gray;
      dst_ptr <= gray2bin(sync_m);
    end
  end

endmodule

`default_nettype wire

// ==== design/asym_mem.sv ====
// dual-clock RAM, one wide beat in and one narrow sample out
// sample 0 of a beat sits in the low bits of the write word
// the read port is registered: data follows the address by one rd_clk cycle
// no reset, contents are undefined until written

`default_nettype none

module asym_mem (
  input  logic                               wr_clk,
  input  logic                               we,
  input  dacfifo_pkg::axi_addr_t             waddr,
  input  logic [dacfifo_pkg::AXI_DATA_W-1:0] wdata,
  input  logic                               rd_clk,
  input  dacfifo_pkg::dac_addr_t             raddr,
  output dacfifo_pkg::sample_t               rdata
);

  import dacfifo_pkg::*;

  logic [AXI_DATA_W-1:0] mem [2**AXI_ADDR_W];
  logic [AXI_DATA_W-1:0] rd_word;
  axi_addr_t             rd_beat;
  logic [SEL_W-1:0]      rd_sel;

  // write port
  always_ff @(posedge wr_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // upper address bits pick the beat, lower bits the sample in it
  assign rd_beat = raddr[DAC_ADDR_W-1:SEL_W];
  assign rd_sel  = raddr[SEL_W-1:0];
  assign rd_word = mem[rd_beat];

  // read port
  always_ff @(posedge rd_clk) begin
    rdata <= rd_word[rd_sel*DAC_DATA_W +: DAC_DATA_W];
  end

endmodule

`default_nettype wire

// ==== design/dacfifo_wr.sv ====
// write-side control of the playback buffer, all in axi_clk
// xfer_req low clears the whole write side and holds wr_ready low
// one block per transfer: after the beat with last, wr_ready stays low
// until xfer_req is dropped and raised again
// rd_addr_sync lags the reader by a few cycles, so the fill seen here
// is never below the real fill

`default_nettype none

module dacfifo_wr (
  input  logic                               axi_clk,
  input  logic                               xfer_req,
  input  dacfifo_pkg::beat_t                 wr_beat,
  output logic                               wr_ready,
  input  dacfifo_pkg::dac_addr_t             rd_addr_sync,
  output logic                               mem_we,
  output dacfifo_pkg::axi_addr_t             mem_waddr,
  output logic [dacfifo_pkg::AXI_DATA_W-1:0] mem_wdata,
  output dacfifo_pkg::axi_addr_t             wr_addr,
  output dacfifo_pkg::axi_addr_t             last_addr,
  output logic                               last_seen
);

  import dacfifo_pkg::*;

  logic                accept;
  axi_addr_t           rd_beat;
  logic [AXI_ADDR_W:0] fill_s;
  axi_addr_t           fill_q;

  // ********************
  // beat acceptance
  // ********************

  assign accept = wr_beat.valid & wr_ready;

  assign mem_we    = accept;
  assign mem_waddr = wr_addr;
  assign mem_wdata = wr_beat.data;

  always_ff @(posedge axi_clk) begin
    if (!xfer_req) begin
      wr_addr   <= '0;
      last_addr <= '0;
      last_seen <= 1'b0;
    end else if (accept) begin
      wr_addr <= wr_addr + 1'b1;
      // remember where the block ends
      if (wr_beat.last) begin
        last_addr <= wr_addr;
        last_seen <= 1'b1;
      end
    end
  end

  // ********************
  // fill and ready
  // ********************

  // reader position in whole beats, a partly read beat still counts as full
  assign rd_beat = rd_addr_sync[DAC_ADDR_W-1:SEL_W];

  // extra top bit keeps the difference positive across the wrap
  assign fill_s = {1'b1, wr_addr} - {1'b0, rd_beat};

  always_ff @(posedge axi_clk) begin
    if (!xfer_req) begin
      fill_q   <= '0;
      wr_ready <= 1'b0;
    end else begin
      fill_q <= fill_s[AXI_ADDR_W-1:0];
      if (last_seen || (accept && wr_beat.last)) begin
        wr_ready <= 1'b0;
      end else if (fill_q >= axi_addr_t'(AXI_THR_HI)) begin
        // one burst of headroom covers the beats still in flight
        wr_ready <= 1'b0;
      end else if (fill_q <= axi_addr_t'(AXI_THR_LO)) begin
        wr_ready <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dacfifo_rd.sv ====
// read-side control of the playback buffer, all in dac_clk
// dac_rst is synchronous; xfer_req is synchronized here by three flops
// last_beats must be stable for the whole block
// playback starts once the fill passes the initial threshold, or once the
// last beat is in memory for blocks shorter than that
// the final beat must not be read before last_seen has crossed over,
// i.e. playback should not run dry right at the end of a block

`default_nettype none

module dacfifo_rd (
  input  logic                     dac_clk,
  input  logic                     dac_rst,
  input  logic                     xfer_req,
  input  dacfifo_pkg::last_beats_t last_beats,
  input  dacfifo_pkg::dac_addr_t   wr_addr_sync,
  input  dacfifo_pkg::dac_addr_t   last_addr_sync,
  input  logic                     last_seen,
  input  logic                     dac_valid,
  output dacfifo_pkg::dac_addr_t   mem_raddr,
  output dacfifo_pkg::dac_addr_t   rd_addr,
  output logic                     dac_dvalid,
  output logic                     dac_xfer_out,
  output logic                     dac_unf
);

  import dacfifo_pkg::*;

  logic [2:0]  xfer_m;
  logic [2:0]  last_m;
  last_beats_t last_beats_m;
  last_beats_t last_beats_q;

  logic        rd_clr;
  logic        last_in_mem;
  logic        mem_enable;
  dac_addr_t   fill_s;
  dac_addr_t   fill_q;
  dac_addr_t   end_addr;
  logic        in_last_beat;
  logic        trim_s;
  logic        accept;
  logic        rd_pend;

  // ********************
  // clock crossing
  // ********************

  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      xfer_m       <= '0;
      last_beats_m <= '0;
      last_beats_q <= '0;
    end else begin
      xfer_m       <= {xfer_m[1:0], xfer_req};
      last_beats_m <= last_beats;
      last_beats_q <= last_beats_m;
    end
  end

  assign dac_xfer_out = xfer_m[2];

  // clear one cycle ahead of dac_xfer_out so that no sample trails it
  assign rd_clr = dac_rst | ~xfer_m[1];

  // three flops so the last address has settled when the flag arrives
  always_ff @(posedge dac_clk) begin
    if (rd_clr) begin
      last_m <= '0;
    end else begin
      last_m <= {last_m[1:0], last_seen};
    end
  end

  assign last_in_mem = last_m[2];

  // ********************
  // fill and playback start
  // ********************

  // current pointers, so a request in flight is already accounted for
  assign fill_s = wr_addr_sync - rd_addr;

  always_ff @(posedge dac_clk) begin
    if (rd_clr) begin
      fill_q     <= '0;
      mem_enable <= 1'b0;
    end else begin
      fill_q <= fill_s;
      if ((fill_q > dac_addr_t'(DAC_THR_INIT)) || last_in_mem) begin
        mem_enable <= 1'b1;
      end
    end
  end

  // ********************
  // read address
  // ********************

  assign end_addr = last_addr_sync + dac_addr_t'(MEM_RATIO);

  assign in_last_beat = last_in_mem &&
                        (rd_addr[DAC_ADDR_W-1:SEL_W] == last_addr_sync[DAC_ADDR_W-1:SEL_W]);

  // last valid sample of a short final beat, jump past the rest
  assign trim_s = in_last_beat && (last_beats_q != '0) &&
                  (rd_addr[SEL_W-1:0] == last_beats_q - 1'b1);

  assign accept = dac_valid & mem_enable & (fill_s != '0);

  always_ff @(posedge dac_clk) begin
    if (rd_clr) begin
      rd_addr    <= '0;
      rd_pend    <= 1'b0;
      dac_dvalid <= 1'b0;
      dac_unf    <= 1'b0;
    end else begin
      if (accept) begin
        rd_addr <= trim_s ? end_addr : rd_addr + 1'b1;
      end
      // memory read takes one more cycle
      rd_pend    <= accept;
      dac_dvalid <= rd_pend;
      // a request that finds nothing to read
      dac_unf    <= dac_valid & mem_enable & (fill_s == '0);
    end
  end

  // address of the sample being served goes to the memory
  always_ff @(posedge dac_clk) begin
    if (accept) begin
      mem_raddr <= rd_addr;
    end
  end

endmodule

`default_nettype wire

// ==== design/dacfifo_top.sv ====
// playback buffer: 64-bit beats in on axi_clk, 16-bit samples out on dac_clk
// the write side is cleared by xfer_req low, the read side by dac_rst
// or by the synchronized xfer_req
// xfer_req has to stay low for several dac_clk cycles on a restart

`default_nettype none

module dacfifo_top (
  input  logic                     axi_clk,
  input  logic                     xfer_req,
  input  dacfifo_pkg::beat_t       wr_beat,
  output logic                     wr_ready,
  input  dacfifo_pkg::last_beats_t last_beats,
  input  logic                     dac_clk,
  input  logic                     dac_rst,
  input  logic                     dac_valid,
  output dacfifo_pkg::sample_t     dac_data,
  output logic                     dac_dvalid,
  output logic                     dac_xfer_out,
  output logic                     dac_unf
);

  import dacfifo_pkg::*;

  logic                  mem_we;
  axi_addr_t             mem_waddr;
  logic [AXI_DATA_W-1:0] mem_wdata;
  axi_addr_t             wr_addr;
  axi_addr_t             last_addr;
  logic                  last_seen;
  axi_addr_t             wr_addr_dst;
  axi_addr_t             last_addr_dst;
  dac_addr_t             wr_addr_sync;
  dac_addr_t             last_addr_sync;
  dac_addr_t             rd_addr;
  dac_addr_t             rd_addr_sync;
  dac_addr_t             mem_raddr;

  dacfifo_wr i_wr (
    .axi_clk      (axi_clk),
    .xfer_req     (xfer_req),
    .wr_beat      (wr_beat),
    .wr_ready     (wr_ready),
    .rd_addr_sync (rd_addr_sync),
    .mem_we       (mem_we),
    .mem_waddr    (mem_waddr),
    .mem_wdata    (mem_wdata),
    .wr_addr      (wr_addr),
    .last_addr    (last_addr),
    .last_seen    (last_seen)
  );

  asym_mem i_mem (
    .wr_clk (axi_clk),
    .we     (mem_we),
    .waddr  (mem_waddr),
    .wdata  (mem_wdata),
    .rd_clk (dac_clk),
    .raddr  (mem_raddr),
    .rdata  (dac_data)
  );

  // beat addresses into dac_clk, scaled to sample addresses afterwards
  gray_sync #(.ptr_t(axi_addr_t)) i_wr_sync (
    .src_clk (axi_clk),
    .dst_clk (dac_clk),
    .clr     (~dac_xfer_out),
    .src_ptr (wr_addr),
    .dst_ptr (wr_addr_dst)
  );

  gray_sync #(.ptr_t(axi_addr_t)) i_last_sync (
    .src_clk (axi_clk),
    .dst_clk (dac_clk),
    .clr     (~dac_xfer_out),
    .src_ptr (last_addr),
    .dst_ptr (last_addr_dst)
  );

  assign wr_addr_sync   = {wr_addr_dst, {SEL_W{1'b0}}};
  assign last_addr_sync = {last_addr_dst, {SEL_W{1'b0}}};

  // reader sample address back to axi_clk; its beat bits stay single-step
  // in gray even when a trimmed beat is skipped
  gray_sync #(.ptr_t(dac_addr_t)) i_rd_sync (
    .src_clk (dac_clk),
    .dst_clk (axi_clk),
    .clr     (~xfer_req),
    .src_ptr (rd_addr),
    .dst_ptr (rd_addr_sync)
  );

  dacfifo_rd i_rd (
    .dac_clk        (dac_clk),
    .dac_rst        (dac_rst),
    .xfer_req       (xfer_req),
    .last_beats     (last_beats),
    .wr_addr_sync   (wr_addr_sync),
    .last_addr_sync (last_addr_sync),
    .last_seen      (last_seen),
    .dac_valid      (dac_valid),
    .mem_raddr      (mem_raddr),
    .rd_addr        (rd_addr),
    .dac_dvalid     (dac_dvalid),
    .dac_xfer_out   (dac_xfer_out),
    .dac_unf        (dac_unf)
  );

endmodule

`default_nettype wire

// ==== tb/dacfifo_chk.sv ====
// handshake and flag assertions bound into dacfifo_top
// checks are held off while dac_rst is high

`default_nettype none

module dacfifo_chk (
  input logic               axi_clk,
  input logic               dac_clk,
  input logic               dac_rst,
  input logic               xfer_req,
  input dacfifo_pkg::beat_t wr_beat,
  input logic               wr_ready,
  input logic               dac_dvalid,
  input logic               dac_xfer_out
);

  // number of failed assertions
  int fail_cnt = 0;

  // a stalled beat keeps its contents
  a_beat_stable : assert property (@(posedge axi_clk) disable iff (dac_rst)
    (wr_beat.valid && !wr_ready) |=> $stable(wr_beat))
    else begin
      $error("wr_beat changed while stalled");
      fail_cnt++;
    end

  a_dvalid_xfer : assert property (@(posedge dac_clk) disable iff (dac_rst)
    !dac_xfer_out |-> !dac_dvalid)
    else begin
      $error("dac_dvalid without dac_xfer_out");
      fail_cnt++;
    end

  // ready is cleared on the edge that sees xfer_req low
  a_ready_idle : assert property (@(posedge axi_clk) disable iff (dac_rst)
    !xfer_req |=> !wr_ready)
    else begin
      $error("wr_ready high while xfer_req low");
      fail_cnt++;
    end

endmodule

bind dacfifo_top dacfifo_chk chk_i (
  .axi_clk      (axi_clk),
  .dac_clk      (dac_clk),
  .dac_rst      (dac_rst),
  .xfer_req     (xfer_req),
  .wr_beat      (wr_beat),
  .wr_ready     (wr_ready),
  .dac_dvalid   (dac_dvalid),
  .dac_xfer_out (dac_xfer_out)
);

`default_nettype wire

// ==== tb/dacfifo_tb.sv ====
// directed testbench for the DAC playback buffer
// beats go in on axi_clk (period 30), samples come out on dac_clk (period 40)
// outputs are sampled on falling edges, inputs driven on rising edges
// each test restarts the transfer and sends one block

`default_nettype none

module dacfifo_tb;

  import dacfifo_pkg::*;

  localparam int MAX_CYCLES = 4000;

  logic        axi_clk = 1'b0;
  logic        dac_clk = 1'b0;
  logic        dac_rst;
  logic        xfer_req;
  beat_t       wr_beat;
  logic        wr_ready;
  last_beats_t last_beats;
  logic        dac_valid;
  sample_t     dac_data;
  logic        dac_dvalid;
  logic        dac_xfer_out;
  logic        dac_unf;

  sample_t     exp_q[$];
  int          n_dvalid;
  int          n_req;
  int          n_stall;
  int          n_acc;
  int          cycles;
  logic        gap_on;
  logic [1:0]  req_hist;
  int          req_idx_d1;
  int          req_idx_d2;
  int          last_req_idx;

  dacfifo_top dacfifo_top_i (
    .axi_clk      (axi_clk),
    .xfer_req     (xfer_req),
    .wr_beat      (wr_beat),
    .wr_ready     (wr_ready),
    .last_beats   (last_beats),
    .dac_clk      (dac_clk),
    .dac_rst      (dac_rst),
    .dac_valid    (dac_valid),
    .dac_data     (dac_data),
    .dac_dvalid   (dac_dvalid),
    .dac_xfer_out (dac_xfer_out),
    .dac_unf      (dac_unf)
  );

  always #15 axi_clk = ~axi_clk;
  always #20 dac_clk = ~dac_clk;

  task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
    if (act !== exp) begin
      $display("ERROR %0t: %s got %0h expected %0h", $time, what, act, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // ********************
  // monitors
  // ********************

  always @(negedge dac_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run went past %0d dac_clk cycles", MAX_CYCLES);
      $display("tests failed");
      $fatal(1);
    end
    if (dac_dvalid === 1'b1) begin
      n_dvalid++;
      // a sample answers the request made two cycles earlier
      check_eq(req_hist[1], 1'b1, "request two cycles before dac_dvalid");
      last_req_idx = req_idx_d2;
      if (exp_q.size() == 0) begin
        $display("a sample came out at %0t when none was expected", $time);
        $display("tests failed");
        $fatal(1);
      end
      check_eq(dac_data, exp_q.pop_front(), "sample");
    end
    req_hist   = {req_hist[0], dac_valid};
    req_idx_d2 = req_idx_d1;
    if (dac_valid) n_req++;
    req_idx_d1 = n_req;
  end

  // values seen here are the ones the next rising edge samples
  always @(negedge axi_clk) begin
    if (xfer_req && wr_beat.valid && !wr_ready) n_stall++;
    if (xfer_req && wr_beat.valid && wr_ready) n_acc++;
  end

  // ********************
  // stimulus helpers
  // ********************

  task automatic send_block(input int n, input last_beats_t lb);
    beat_t b;
    int    keep;
    @(posedge axi_clk);
    for (int i = 0; i < n; i++) begin
      if ($urandom_range(3) == 0) begin
        wr_beat <= '0;
        @(posedge axi_clk);
      end
      b.valid = 1'b1;
      b.last  = (i == n - 1);
      b.data  = {$urandom, $urandom};
      keep    = (b.last && lb != 0) ? int'(lb) : MEM_RATIO;
      for (int s = 0; s < keep; s++) begin
        exp_q.push_back(b.data[s*DAC_DATA_W +: DAC_DATA_W]);
      end
      wr_beat <= b;
      do @(negedge axi_clk); while (!wr_ready);
      @(posedge axi_clk);
    end
    wr_beat <= '0;
  endtask

  // drop xfer_req until the read side has cleared and then start again
  task automatic restart(input last_beats_t lb);
    @(posedge axi_clk);
    xfer_req <= 1'b0;
    do @(negedge dac_clk); while (dac_xfer_out);
    check_eq(dac_unf, 1'b0, "dac_unf after restart");
    repeat (4) @(posedge dac_clk);
    @(posedge axi_clk);
    last_beats <= lb;
    xfer_req   <= 1'b1;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge dac_clk);
    repeat (20) @(negedge dac_clk);
  endtask

  task automatic set_dac_valid(input logic v);
    @(posedge dac_clk);
    dac_valid <= v;
  endtask

  // ********************
  // tests
  // ********************

  task automatic full_block_and_underflow();
    int start;
    set_dac_valid(1'b1);
    restart(2'd0);
    n_acc = 0;
    start = n_dvalid;
    fork
      send_block(32, 2'd0);
      begin
        // playback waits for more than the initial fill in samples
        while (n_dvalid == start) @(posedge dac_clk);
        check_eq(n_acc > DAC_THR_INIT / MEM_RATIO, 1'b1, "beats stored at playback start");
      end
    join
    wait_drained();
    check_eq(n_dvalid - start, 128, "samples of full block");
    // reader caught up with the writer and keeps asking
    check_eq(dac_unf, 1'b1, "dac_unf after drain");
    start = n_dvalid;
    repeat (30) @(negedge dac_clk);
    check_eq(n_dvalid - start, 0, "samples after underflow");
  endtask

  task automatic trimmed_blocks();
    int start;
    for (int lb = 1; lb <= 3; lb++) begin
      restart(last_beats_t'(lb));
      start = n_dvalid;
      send_block(20, last_beats_t'(lb));
      wait_drained();
      check_eq(n_dvalid - start, 76 + lb, "samples of trimmed block");
    end
  endtask

  task automatic back_pressure();
    int start;
    int held;
    set_dac_valid(1'b0);
    restart(2'd0);
    n_stall = 0;
    n_acc   = 0;
    start   = n_dvalid;
    fork
      send_block(64, 2'd0);
      begin
        while (n_stall == 0) @(negedge axi_clk);
        held = n_acc;
        check_eq(held < 64, 1'b1, "ready fell before overflow");
        repeat (20) @(negedge dac_clk);
        check_eq(n_acc, held, "no beat accepted while full");
        set_dac_valid(1'b1);
      end
    join
    wait_drained();
    check_eq(n_dvalid - start, 256, "samples after back-pressure");
  endtask

  task automatic gapped_requests();
    int start;
    int first_req;
    restart(2'd0);
    start     = n_dvalid;
    first_req = 0;
    gap_on    = 1'b1;
    fork
      while (gap_on) begin
        @(posedge dac_clk);
        dac_valid <= 1'($urandom_range(1));
      end
      begin
        send_block(32, 2'd0);
        while (exp_q.size() != 0) @(negedge dac_clk);
        gap_on = 1'b0;
      end
      begin
        while (n_dvalid == start) @(posedge dac_clk);
        first_req = last_req_idx;
      end
    join
    repeat (20) @(negedge dac_clk);
    check_eq(n_dvalid - start, 128, "samples with gapped requests");
    // the writer stays ahead, so every request during playback is served
    check_eq(last_req_idx - first_req + 1, 128, "requests served during playback");
  endtask

  initial begin
    void'($urandom(32'h33c5));
    dac_rst      = 1'b1;
    xfer_req     = 1'b0;
    wr_beat      = '0;
    last_beats   = '0;
    dac_valid    = 1'b0;
    gap_on       = 1'b0;
    n_dvalid     = 0;
    n_req        = 0;
    n_stall      = 0;
    n_acc        = 0;
    cycles       = 0;
    req_hist     = '0;
    req_idx_d1   = 0;
    req_idx_d2   = 0;
    last_req_idx = 0;
    repeat (10) @(posedge dac_clk);
    dac_rst <= 1'b0;
    repeat (4) @(posedge dac_clk);
    full_block_and_underflow();
    trimmed_blocks();
    back_pressure();
    gapped_requests();
    if (dacfifo_top_i.chk_i.fail_cnt == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
design/dacfifo_pkg.sv
design/gray_sync.sv
design/asym_mem.sv
design/dacfifo_wr.sv
design/dacfifo_rd.sv
design/dacfifo_top.sv
tb/dacfifo_chk.sv
tb/dacfifo_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the playback buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dacfifo_tb -f flist.f -o dacfifo_sim \
  || { echo "build failed"; exit 1; }
out="$(./obj_dir/dacfifo_sim)"
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || exit 1
